/* design/iob_bus_pkg.sv */
package iob_bus_pkg;

   // Native bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Master to follower request
   // A request with wstrb all zero is a read
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] address;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } iob_req_t;

   // Follower to master response
   // rvalid marks rdata for one cycle, ready accepts the request
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_rsp_t;

endpackage

/* design/iob_map_pkg.sv */
package iob_map_pkg;

   import iob_bus_pkg::*;

   // Followers on the split, selected by address bits starting at SEL_LSB
   localparam int N_FOLLOWERS = 2;
   localparam int SEL_W       = $clog2(N_FOLLOWERS);
   localparam int SEL_LSB     = 12;
   localparam int F_SRAM      = 0;
   localparam int F_TIMER     = 1;

   // Scratch memory, word addressed by address bits 9:2
   localparam int SRAM_DEPTH = 256;
   localparam int SRAM_AW    = 8;

   // Timer register word offsets
   localparam int TMR_CTRL   = 0;  // bit 0 enable, bit 1 auto-reload
   localparam int TMR_LOAD   = 1;
   localparam int TMR_COUNT  = 2;  // read-only
   localparam int TMR_STATUS = 3;  // bit 0 expired, write 1 to clear

   // CSR block to timer
   typedef struct packed {
      logic              enable;
      logic              auto_reload;
      logic [DATA_W-1:0] load;
      logic              start;
   } tmr_cfg_t;

   // Timer to CSR block
   typedef struct packed {
      logic [DATA_W-1:0] count;
      logic              expire;
   } tmr_stat_t;

endpackage

/* design/iob_mux.sv */
`timescale 1ns/1ns

// N-way selector, the payload can be any packed type
module iob_mux #(
   parameter type payload_t = logic,
   parameter int  N         = 2
) (
   input  logic [$clog2(N)-1:0] sel_i,
   input  payload_t             data_i [N],
   output payload_t             data_o
);

   payload_t sel_data;

   // Scan all inputs so an index outside 0..N-1 yields the first entry
   always_comb begin
      sel_data = data_i[0];
      for (int i = 1; i < N; i++) begin
         if (sel_i == i[$clog2(N)-1:0]) begin
            sel_data = data_i[i];
         end
      end
   end

   assign data_o = sel_data;

endmodule

/* design/iob_periph_top.sv */
`timescale 1ns/1ns

// Peripheral subsystem, scratch SRAM and timer behind one bus split
module iob_periph_top
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  iob_req_t m_req_i,
   output iob_rsp_t m_rsp_o,
   output logic     irq_o
);

   iob_req_t  f_req [N_FOLLOWERS];
   iob_rsp_t  f_rsp [N_FOLLOWERS];
   tmr_cfg_t  tmr_cfg;
   tmr_stat_t tmr_stat;

   iob_split u_split (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .m_req_i(m_req_i),
      .m_rsp_o(m_rsp_o),
      .f_req_o(f_req),
      .f_rsp_i(f_rsp)
   );

   iob_sram u_sram (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .req_i  (f_req[F_SRAM]),
      .rsp_o  (f_rsp[F_SRAM])
   );

   iob_timer_csr u_timer_csr (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .req_i  (f_req[F_TIMER]),
      .rsp_o  (f_rsp[F_TIMER]),
      .cfg_o  (tmr_cfg),
      .stat_i (tmr_stat),
      .irq_o  (irq_o)
   );

   iob_timer u_timer (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .cfg_i  (tmr_cfg),
      .stat_o (tmr_stat)
   );

endmodule

/* design/iob_split.sv */
`timescale 1ns/1ns

// Routes one master request to the follower addressed by the select field
// and brings that follower's response back to the master
module iob_split
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,

   // Master side
   input  iob_req_t m_req_i,
   output iob_rsp_t m_rsp_o,

   // Follower side
   output iob_req_t f_req_o [N_FOLLOWERS],
   input  iob_rsp_t f_rsp_i [N_FOLLOWERS]
);

   logic [SEL_W-1:0] sel_dec;
   logic [SEL_W-1:0] sel_r;
   logic             f_ready [N_FOLLOWERS];
   logic             m_ready;
   logic             accept;
   iob_rsp_t         rsp_sel;

   // Follower index straight from the address
   assign sel_dec = m_req_i.address[SEL_LSB +: SEL_W];

   // Address, wdata and wstrb are broadcast, avalid only to the addressed one
   always_comb begin
      for (int i = 0; i < N_FOLLOWERS; i++) begin
         f_req_o[i]        = m_req_i;
         f_req_o[i].avalid = m_req_i.avalid && (sel_dec == i[SEL_W-1:0]);
         f_ready[i]        = f_rsp_i[i].ready;
      end
   end

   // Ready follows the follower being addressed now
   iob_mux #(
      .payload_t(logic),
      .N        (N_FOLLOWERS)
   ) u_mux_ready (
      .sel_i (sel_dec),
      .data_i(f_ready),
      .data_o(m_ready)
   );

   assign accept = m_req_i.avalid && m_ready;

   // Remember who took the last request, its response arrives next cycle
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sel_r <= SEL_W'(F_SRAM);
      end else if (accept) begin
         sel_r <= sel_dec;
      end
   end

   // rdata and rvalid come from the previously accepted follower
   iob_mux #(
      .payload_t(iob_rsp_t),
      .N        (N_FOLLOWERS)
   ) u_mux_rsp (
      .sel_i (sel_r),
      .data_i(f_rsp_i),
      .data_o(rsp_sel)
   );

   assign m_rsp_o.rdata  = rsp_sel.rdata;
   assign m_rsp_o.rvalid = rsp_sel.rvalid;
   assign m_rsp_o.ready  = m_ready;

endmodule

/* design/iob_sram.sv */
`timescale 1ns/1ns

// Scratch word memory on the native bus
// One wait state follows every accepted access
module iob_sram
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  iob_req_t req_i,
   output iob_rsp_t rsp_o
);

   logic [DATA_W-1:0]  mem [SRAM_DEPTH];
   logic [SRAM_AW-1:0] word_addr;
   logic [DATA_W-1:0]  rdata_r;
   logic               wait_r;
   logic               rvalid_r;
   logic               accept;

   assign word_addr = req_i.address[2 +: SRAM_AW];
   assign accept    = req_i.avalid && !wait_r;

   // Handshake state
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wait_r   <= 1'b0;
         rvalid_r <= 1'b0;
      end else begin
         wait_r   <= accept;
         rvalid_r <= accept && (req_i.wstrb == '0);
      end
   end

   // Byte lanes written per strobe, old word read out on every access
   always_ff @(posedge clk_i) begin
      if (accept) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
         rdata_r <= mem[word_addr];
      end
   end

   assign rsp_o.rdata  = rdata_r;
   assign rsp_o.rvalid = rvalid_r;
   assign rsp_o.ready  = !wait_r;

endmodule

/* design/iob_timer.sv */
`timescale 1ns/1ns

// Down counter, expires one edge after reaching zero
module iob_timer
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  tmr_cfg_t  cfg_i,
   output tmr_stat_t stat_o
);

   logic [DATA_W-1:0] count_r;
   logic              at_zero;
   logic              expire;

   assign at_zero = (count_r == '0);

   // A start in the same cycle takes precedence over expiry
   assign expire = cfg_i.enable && at_zero && !cfg_i.start;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_r <= '0;
      end else if (cfg_i.start) begin
         count_r <= cfg_i.load;
      end else if (expire) begin
         // One-shot holds at zero, enable is dropped by the CSR block
         if (cfg_i.auto_reload) begin
            count_r <= cfg_i.load;
         end
      end else if (cfg_i.enable) begin
         count_r <= count_r - 1'b1;
      end
   end

   assign stat_o.count  = count_r;
   assign stat_o.expire = expire;

endmodule

/* design/iob_timer_csr.sv */
`timescale 1ns/1ns

// Control and status registers of the timer, as a bus follower
module iob_timer_csr
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  iob_req_t  req_i,
   output iob_rsp_t  rsp_o,
   output tmr_cfg_t  cfg_o,
   input  tmr_stat_t stat_i,
   output logic      irq_o
);

   logic [1:0]        offset;
   logic              wr;
   logic              rd;
   logic              ctrl_wr;
   logic              enable_r;
   logic              auto_r;
   logic [DATA_W-1:0] load_r;
   logic              expired_r;
   logic              rvalid_r;
   logic [DATA_W-1:0] rdata_r;
   logic [DATA_W-1:0] rd_words [4];
   logic [DATA_W-1:0] rd_word;

   // Always ready, so avalid alone accepts
   assign offset  = req_i.address[3:2];
   assign wr      = req_i.avalid && (req_i.wstrb != '0);
   assign rd      = req_i.avalid && (req_i.wstrb == '0);
   assign ctrl_wr = wr && req_i.wstrb[0] && (offset == 2'(TMR_CTRL));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         enable_r  <= 1'b0;
         auto_r    <= 1'b0;
         load_r    <= '0;
         expired_r <= 1'b0;
         rvalid_r  <= 1'b0;
      end else begin
         rvalid_r <= rd;
         // A one-shot expiry drops enable unless software rewrites CTRL
         if (ctrl_wr) begin
            enable_r <= req_i.wdata[0];
            auto_r   <= req_i.wdata[1];
         end else if (stat_i.expire && !auto_r) begin
            enable_r <= 1'b0;
         end
         if (wr && (offset == 2'(TMR_LOAD))) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (req_i.wstrb[b]) begin
                  load_r[8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
            end
         end
         // Set beats clear
         if (stat_i.expire) begin
            expired_r <= 1'b1;
         end else if (wr && req_i.wstrb[0] && req_i.wdata[0]
                      && (offset == 2'(TMR_STATUS))) begin
            expired_r <= 1'b0;
         end
      end
   end

   always_comb begin
      rd_words[TMR_CTRL]   = {{(DATA_W-2){1'b0}}, auto_r, enable_r};
      rd_words[TMR_LOAD]   = load_r;
      rd_words[TMR_COUNT]  = stat_i.count;
      rd_words[TMR_STATUS] = {{(DATA_W-1){1'b0}}, expired_r};
   end

   iob_mux #(
      .payload_t(logic [DATA_W-1:0]),
      .N        (4)
   ) u_mux_rd (
      .sel_i (offset),
      .data_i(rd_words),
      .data_o(rd_word)
   );

   // Readback captured on the accepting edge
   always_ff @(posedge clk_i) begin
      if (rd) begin
         rdata_r <= rd_word;
      end
   end

   assign rsp_o.rdata  = rdata_r;
   assign rsp_o.rvalid = rvalid_r;
   assign rsp_o.ready  = 1'b1;

   // Start loads the counter on the same edge as the CTRL write
   assign cfg_o.enable      = enable_r;
   assign cfg_o.auto_reload = auto_r;
   assign cfg_o.load        = load_r;
   assign cfg_o.start       = ctrl_wr && req_i.wdata[0];

   assign irq_o = expired_r;

endmodule

/* iob_periph_top.f */
design/iob_bus_pkg.sv
design/iob_map_pkg.sv
design/iob_mux.sv
design/iob_split.sv
design/iob_sram.sv
design/iob_timer_csr.sv
design/iob_timer.sv
design/iob_periph_top.sv
sim/iob_split_asserts.sv
sim/iob_periph_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f iob_periph_top.f \
   --top-module iob_periph_top_tb --Mdir obj_dir -o iob_periph_top_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/iob_periph_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "test failed" "$LOG"; then
   exit 1
fi

exit 0

/* sim/iob_periph_stim.txt */
# op address wdata wstrb expected, all hex
# W write, R read and compare, I wait address cycles then compare irq, G gap mode in wdata
G 00000000 00000001 0 00000000
W 00000000 11223344 f 00000000
W 00000010 a5a5a5a5 f 00000000
W 000003fc deadbeef f 00000000
R 00000000 00000000 0 11223344
R 00000010 00000000 0 a5a5a5a5
R 000003fc 00000000 0 deadbeef
W 00000000 000000cc 1 00000000
W 00000010 5a5a0000 c 00000000
W 000003fc 00770000 4 00000000
R 00000000 00000000 0 112233cc
R 00000010 00000000 0 5a5aa5a5
R 000003fc 00000000 0 de77beef
G 00000000 00000000 0 00000000
W 00000020 00000001 f 00000000
W 00000024 00000002 f 00000000
W 00000028 00000003 f 00000000
R 00000020 00000000 0 00000001
R 00000024 00000000 0 00000002
R 00000028 00000000 0 00000003
W 00001004 00000005 f 00000000
R 00000024 00000000 0 00000002
R 00001004 00000000 0 00000005
W 00001000 00000001 f 00000000
I 00000005 00000000 0 00000000
I 00000001 00000000 0 00000001
R 00001000 00000000 0 00000000
W 0000100c 00000001 f 00000000
I 00000000 00000000 0 00000000
W 00001004 00000003 f 00000000
W 00001000 00000003 f 00000000
I 00000003 00000000 0 00000000
I 00000001 00000000 0 00000001
W 0000100c 00000001 f 00000000
I 00000000 00000000 0 00000000
I 00000002 00000000 0 00000000
I 00000001 00000000 0 00000001
I 00000001 00000000 0 00000001
R 00001008 00000000 0 00000002
R 0000100c 00000000 0 00000001
W 00001000 00000000 f 00000000
W 0000100c 00000001 f 00000000
I 00000000 00000000 0 00000000

/* sim/iob_periph_top_tb.sv */
`timescale 1ns/1ns

module iob_periph_top_tb
   import iob_bus_pkg::*;
();

   // Follower field and SRAM byte window of the address map
   localparam logic [31:0] TIMER_BASE = 32'h0000_1000;
   localparam int          SRAM_BYTES = 1024;

   logic     clk_i;
   logic     reset_i;
   iob_req_t m_req_i;
   iob_rsp_t m_rsp_o;
   logic     irq_o;

   byte         op_q [$];
   logic [31:0] addr_q [$];
   logic [31:0] wdata_q [$];
   logic [3:0]  wstrb_q [$];
   logic [31:0] exp_q [$];

   logic [7:0]  sram_bytes [SRAM_BYTES];
   int          stall_count = 0;
   int          cycle_count = 0;
   int          cycle_limit = 1000000;

   iob_periph_top u_dut (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .m_req_i(m_req_i),
      .m_rsp_o(m_rsp_o),
      .irq_o  (irq_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, the run did not finish", cycle_count);
         $display("test failed");
         $fatal(1, "Simulation stopped on timeout");
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
         $display("test failed");
         $fatal(1, "Stopping at first error");
      end
   endtask

   // One transfer, starting and ending on a falling edge
   task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
      int   waits;
      logic got;
      waits = 0;
      got   = 1'b0;
      rdata = '0;
      m_req_i.avalid  = 1'b1;
      m_req_i.address = addr;
      m_req_i.wdata   = wdata;
      m_req_i.wstrb   = wstrb;
      #1;
      while (!m_rsp_o.ready) begin
         stall_count++;
         @(negedge clk_i);
         #1;
      end
      @(posedge clk_i);
      @(negedge clk_i);
      // Idle request while the response is still on its way
      m_req_i = '0;
      if (wstrb == '0) begin
         while (!got) begin
            if (m_rsp_o.rvalid) begin
               rdata = m_rsp_o.rdata;
               got   = 1'b1;
            end else begin
               waits++;
               if (waits >= 4) begin
                  $display("Missing read response for address 0x%08h", addr);
                  $display("test failed");
                  $fatal(1, "Stopping at first error");
               end
               @(negedge clk_i);
            end
         end
      end
   endtask

   // Byte-level model of the scratch SRAM
   task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb);
      for (int b = 0; b < 4; b++) begin
         if (wstrb[b]) begin
            sram_bytes[{addr[9:2], 2'(b)}] = wdata[8*b +: 8];
         end
      end
   endtask

   function automatic logic [31:0] model_read(input logic [31:0] addr);
      logic [31:0] word;
      for (int b = 0; b < 4; b++) begin
         word[8*b +: 8] = sram_bytes[{addr[9:2], 2'(b)}];
      end
      return word;
   endfunction

   task automatic load_stimulus();
      int          fd;
      int          n;
      int          max_wait;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] w;
      logic [31:0] s;
      logic [31:0] e;
      max_wait = 0;
      fd = $fopen("sim/iob_periph_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         $display("test failed");
         $fatal(1, "Stopping at first error");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n <= 0 || line.len() < 2 || line[0] == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h %h %h", op, a, w, s, e);
         if (n != 5) begin
            $display("Malformed stimulus line: %s", line);
            $display("test failed");
            $fatal(1, "Stopping at first error");
         end
         op_q.push_back(op);
         addr_q.push_back(a);
         wdata_q.push_back(w);
         wstrb_q.push_back(s[3:0]);
         exp_q.push_back(e);
         if (op == "I" && int'(a) > max_wait) begin
            max_wait = int'(a);
         end
      end
      $fclose(fd);
      cycle_limit = 40 * op_q.size() + max_wait + 10;
   endtask

   initial begin
      logic [31:0] rdata;
      logic        gaps_on;
      logic        is_sram;
      gaps_on = 1'b0;
      void'($urandom(58));
      reset_i = 1'b1;
      m_req_i = '0;
      load_stimulus();
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      foreach (op_q[i]) begin
         is_sram = (addr_q[i] & TIMER_BASE) == '0;
         if (gaps_on) begin
            repeat ($urandom % 4) @(negedge clk_i);
         end
         case (op_q[i])
            "G": gaps_on = wdata_q[i][0];
            "W": begin
               bus_access(addr_q[i], wdata_q[i], wstrb_q[i], rdata);
               if (is_sram) begin
                  model_write(addr_q[i], wdata_q[i], wstrb_q[i]);
               end
            end
            "R": begin
               // The file's expectation must agree with the SRAM model
               if (is_sram) begin
                  check_value("stim_expected", exp_q[i], model_read(addr_q[i]));
               end
               bus_access(addr_q[i], '0, '0, rdata);
               check_value("m_rsp_o.rdata", rdata, exp_q[i]);
            end
            "I": begin
               repeat (int'(addr_q[i])) @(negedge clk_i);
               check_value("irq_o", {31'b0, irq_o}, exp_q[i]);
            end
            default: begin
               $display("Unknown operation on stimulus line %0d", i);
               $display("test failed");
               $fatal(1, "Stopping at first error");
            end
         endcase
      end

      if (stall_count == 0) begin
         $display("The SRAM never applied back-pressure during the burst");
         $display("test failed");
         $fatal(1, "Stopping at first error");
      end else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

/* sim/iob_split_asserts.sv */
`timescale 1ns/1ns

module iob_split_asserts
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input logic     clk_i,
   input logic     reset_i,
   input iob_req_t m_req_i,
   input iob_rsp_t m_rsp_o,
   input iob_req_t f_req_o [N_FOLLOWERS]
);

   logic [N_FOLLOWERS-1:0] f_avalid;

   always_comb begin
      for (int i = 0; i < N_FOLLOWERS; i++) begin
         f_avalid[i] = f_req_o[i].avalid;
      end
   end

   one_follower_a: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(f_avalid))
      else $error("More than one follower avalid high");

   avalid_from_master_a: assert property (@(posedge clk_i) disable iff (reset_i)
      (f_avalid != '0) |-> m_req_i.avalid)
      else $error("Follower avalid without master avalid");

   rvalid_after_read_a: assert property (@(posedge clk_i) disable iff (reset_i)
      m_rsp_o.rvalid |-> $past(m_req_i.avalid && m_rsp_o.ready && (m_req_i.wstrb == '0)))
      else $error("rvalid without a read accepted on the previous edge");

endmodule

bind iob_split iob_split_asserts u_split_asserts (
   .clk_i  (clk_i),
   .reset_i(reset_i),
   .m_req_i(m_req_i),
   .m_rsp_o(m_rsp_o),
   .f_req_o(f_req_o)
);
